// ==== pcdir_consts.svh ====
// ######################################################################
// PC director constants
// Address, branch metadata and command queue sizing
// ######################################################################

`ifndef PCDIR_CONSTS_SVH
`define PCDIR_CONSTS_SVH

// Virtual address width
`define PCDIR_VADDR_WIDTH 32

// Branch metadata forwarded back to the predictor
`define PCDIR_META_WIDTH 8

// Front-end command FIFO depth
`define PCDIR_CMDQ_DEPTH 4

`endif

// ==== pcdir_pkg.sv ====
// ######################################################################
// PC director package
// Shared vector types and enumerations for the back-end director
// ######################################################################

`include "pcdir_consts.svh"

package pcdir_pkg;

  typedef logic [`PCDIR_VADDR_WIDTH-1:0] vaddr_t;
  typedef logic [`PCDIR_META_WIDTH-1:0]  bmeta_t;

  // Front-end command opcodes
  typedef enum logic [2:0] {
    e_op_state_reset    = 3'd0,
    e_op_pc_redirection = 3'd1,
    e_op_itlb_fence     = 3'd2,
    e_op_icache_fence   = 3'd3,
    e_op_wait           = 3'd4,
    e_op_attaboy        = 3'd5
  } fe_opcode_e;

  typedef enum logic [1:0] {
    e_subop_none,
    e_subop_eret,
    e_subop_trap,
    e_subop_branch_mispredict
  } redirect_subop_e;

  typedef enum logic [1:0] {
    e_not_a_branch,
    e_incorrect_pred_taken,
    e_incorrect_pred_ntaken
  } mispred_reason_e;

  typedef enum logic [1:0] {e_freeze, e_run, e_fence, e_wait} dir_state_e;

endpackage

// ==== npc_tracker.sv ====
// ######################################################################
// NPC tracker
// Holds the next PC expected by the back end, flags a mismatching issue
// and remembers whether the last resolved instruction was a branch
// ######################################################################

`timescale 1ns/10ps

module npc_tracker
  import pcdir_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   br_v_i,
  input  vaddr_t br_npc_i,
  input  logic   br_branch_i,
  input  logic   br_taken_i,
  input  logic   commit_npc_w_v_i,
  input  vaddr_t commit_npc_i,
  input  logic   isd_v_i,
  input  vaddr_t isd_pc_i,
  output vaddr_t expected_npc_o,
  output logic   npc_mismatch_o,
  output logic   poison_isd_o,
  output logic   last_branch_o,
  output logic   last_taken_o
);

  vaddr_t npc_r;
  vaddr_t npc_n;
  logic   npc_w_v;
  logic   branch_pending_r;
  logic   taken_pending_r;
  logic   br_set;
  logic   taken_set;

  // Commit beats a resolving branch
  assign npc_w_v = commit_npc_w_v_i | br_v_i;
  assign npc_n   = commit_npc_w_v_i ? commit_npc_i : br_npc_i;

  assign expected_npc_o = npc_w_v ? npc_n : npc_r;
  assign npc_mismatch_o = isd_v_i & (expected_npc_o != isd_pc_i);
  assign poison_isd_o   = commit_npc_w_v_i | npc_mismatch_o;

  assign br_set    = br_v_i & br_branch_i;
  assign taken_set = br_v_i & br_taken_i;

  assign last_branch_o = branch_pending_r | br_set;
  assign last_taken_o  = taken_pending_r | taken_set;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      npc_r            <= '0;
      branch_pending_r <= 1'b0;
      taken_pending_r  <= 1'b0;
    end
    else
    begin
      if (npc_w_v)
        npc_r <= npc_n;
      // A valid issue consumes the pending branch even when set in the same cycle
      branch_pending_r <= ~isd_v_i & (branch_pending_r | br_set);
      taken_pending_r  <= ~isd_v_i & (taken_pending_r | taken_set);
    end
  end

  a_mismatch_needs_issue: assert property (@(posedge clk_i) disable iff (reset_i)
    npc_mismatch_o |-> isd_v_i);

endmodule

// ==== fe_cmd_encoder.sv ====
// ######################################################################
// Front-end command encoder
// Fixed-priority choice of the next front-end command and its operands
// ######################################################################

`timescale 1ns/10ps

module fe_cmd_encoder
  import pcdir_pkg::*;
(
  input  logic            commit_unfreeze_i,
  input  logic            commit_sfence_i,
  input  logic            commit_wfi_i,
  input  logic            commit_fencei_i,
  input  logic            commit_eret_i,
  input  logic            commit_trap_i,
  input  vaddr_t          commit_npc_i,
  input  logic            isd_v_i,
  input  bmeta_t          isd_meta_i,
  input  logic            irq_waiting_i,
  input  logic            in_wait_i,
  input  vaddr_t          expected_npc_i,
  input  logic            npc_mismatch_i,
  input  logic            last_branch_i,
  input  logic            last_taken_i,
  input  logic            enq_ready_i,
  output logic            enq_v_o,
  output fe_opcode_e      enq_opcode_o,
  output vaddr_t          enq_npc_o,
  output redirect_subop_e enq_subop_o,
  output mispred_reason_e enq_reason_o,
  output logic            enq_taken_o,
  output bmeta_t          enq_meta_o
);

  logic cmd_v;

  always_comb
  begin
    cmd_v        = 1'b1;
    enq_opcode_o = e_op_attaboy;
    enq_npc_o    = commit_npc_i;
    enq_subop_o  = e_subop_none;
    enq_reason_o = e_not_a_branch;
    enq_taken_o  = 1'b0;
    enq_meta_o   = '0;

    if (commit_unfreeze_i)
    begin
      enq_opcode_o = e_op_state_reset;
      enq_npc_o    = expected_npc_i;
    end
    else if (commit_sfence_i)
      enq_opcode_o = e_op_itlb_fence;
    else if (commit_wfi_i)
      enq_opcode_o = e_op_wait;
    else if (commit_fencei_i)
      enq_opcode_o = e_op_icache_fence;
    else if (commit_eret_i)
    begin
      enq_opcode_o = e_op_pc_redirection;
      enq_subop_o  = e_subop_eret;
    end
    else if (commit_trap_i | (in_wait_i & irq_waiting_i))
    begin
      enq_opcode_o = e_op_pc_redirection;
      enq_subop_o  = e_subop_trap;
    end
    else if (npc_mismatch_i)
    begin
      enq_opcode_o = e_op_pc_redirection;
      enq_npc_o    = expected_npc_i;
      enq_subop_o  = e_subop_branch_mispredict;
      enq_meta_o   = isd_meta_i;
      enq_reason_o = ~last_branch_i ? e_not_a_branch
                   : last_taken_i   ? e_incorrect_pred_taken
                   : e_incorrect_pred_ntaken;
    end
    // Correct prediction reported back to the predictor
    else if (isd_v_i & last_branch_i)
    begin
      enq_npc_o   = expected_npc_i;
      enq_taken_o = last_taken_i;
      enq_meta_o  = isd_meta_i;
    end
    else
      cmd_v = 1'b0;
  end

  assign enq_v_o = cmd_v & enq_ready_i;

endmodule

// ==== fe_cmd_queue.sv ====
// ######################################################################
// Front-end command FIFO
// Circular buffer of commands with a valid/yumi read side
// ######################################################################

`timescale 1ns/10ps

`include "pcdir_consts.svh"

module fe_cmd_queue
  import pcdir_pkg::*;
#(
  parameter int depth_p = `PCDIR_CMDQ_DEPTH
)
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            enq_v_i,
  input  fe_opcode_e      enq_opcode_i,
  input  vaddr_t          enq_npc_i,
  input  redirect_subop_e enq_subop_i,
  input  mispred_reason_e enq_reason_i,
  input  logic            enq_taken_i,
  input  bmeta_t          enq_meta_i,
  output logic            enq_ready_o,
  output fe_opcode_e      fe_cmd_opcode_o,
  output vaddr_t          fe_cmd_npc_o,
  output redirect_subop_e fe_cmd_subop_o,
  output mispred_reason_e fe_cmd_reason_o,
  output logic            fe_cmd_taken_o,
  output bmeta_t          fe_cmd_meta_o,
  output logic            fe_cmd_v_o,
  input  logic            fe_cmd_yumi_i,
  output logic            empty_next_o,
  output logic            empty_o,
  output logic            full_o
);

  localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w_lp = $clog2(depth_p + 1);

  fe_opcode_e      opcode_mem [depth_p];
  vaddr_t          npc_mem    [depth_p];
  redirect_subop_e subop_mem  [depth_p];
  mispred_reason_e reason_mem [depth_p];
  logic            taken_mem  [depth_p];
  bmeta_t          meta_mem   [depth_p];

  logic [ptr_w_lp-1:0] rptr_r, wptr_r;
  logic [cnt_w_lp-1:0] count_r, count_n;

  assign empty_o      = (count_r == '0);
  assign full_o       = (count_r == cnt_w_lp'(depth_p));
  assign enq_ready_o  = ~full_o;
  assign fe_cmd_v_o   = ~empty_o;
  assign count_n      = count_r + cnt_w_lp'(enq_v_i) - cnt_w_lp'(fe_cmd_yumi_i);
  assign empty_next_o = (count_n == '0);

  assign fe_cmd_opcode_o = opcode_mem[rptr_r];
  assign fe_cmd_npc_o    = npc_mem[rptr_r];
  assign fe_cmd_subop_o  = subop_mem[rptr_r];
  assign fe_cmd_reason_o = reason_mem[rptr_r];
  assign fe_cmd_taken_o  = taken_mem[rptr_r];
  assign fe_cmd_meta_o   = meta_mem[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (enq_v_i)
    begin
      opcode_mem[wptr_r] <= enq_opcode_i;
      npc_mem[wptr_r]    <= enq_npc_i;
      subop_mem[wptr_r]  <= enq_subop_i;
      reason_mem[wptr_r] <= enq_reason_i;
      taken_mem[wptr_r]  <= enq_taken_i;
      meta_mem[wptr_r]   <= enq_meta_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rptr_r  <= '0;
      wptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      count_r <= count_n;
      if (enq_v_i)
        wptr_r <= (wptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : wptr_r + 1'b1;
      if (fe_cmd_yumi_i)
        rptr_r <= (rptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : rptr_r + 1'b1;
    end
  end

  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_cmd_yumi_i |-> fe_cmd_v_o);

  a_no_enq_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    enq_v_i |-> ~full_o);

endmodule

// ==== pc_director_ctrl.sv ====
// ######################################################################
// PC director control
// Boot, run, fence and wait sequencing that holds issue while the
// front end is being redirected
// ######################################################################

`timescale 1ns/10ps

module pc_director_ctrl
  import pcdir_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       freeze_i,
  input  logic       commit_wfi_i,
  input  logic       enq_v_i,
  input  fe_opcode_e enq_opcode_i,
  input  logic       empty_next_i,
  output logic       in_wait_o,
  output logic       suppress_iss_o,
  output logic       unfreeze_o
);

  dir_state_e state_r, state_n;
  logic       fence_cmd_v;

  // Anything but an attaboy forces the front end to refetch
  assign fence_cmd_v = enq_v_i & (enq_opcode_i != e_op_attaboy);

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_freeze:
        if (~freeze_i)
          state_n = e_wait;
      e_wait:
        if (fence_cmd_v)
          state_n = e_fence;
      e_run:
        if (commit_wfi_i)
          state_n = e_wait;
        else if (fence_cmd_v)
          state_n = e_fence;
      e_fence:
        if (empty_next_i)
          state_n = e_run;
      default:
        state_n = e_freeze;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_freeze;
    else
      state_r <= state_n;
  end

  assign in_wait_o      = (state_r == e_wait);
  assign suppress_iss_o = (state_r != e_run);
  assign unfreeze_o     = (state_r == e_freeze) & ~freeze_i;

endmodule

// ==== pc_director.sv ====
// ######################################################################
// Back-end PC director
// Tracks the expected next PC and turns mispredicts and commit events
// into queued front-end commands
// ######################################################################

`timescale 1ns/10ps

module pc_director
  import pcdir_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            freeze_i,
  input  logic            irq_waiting_i,
  input  logic            br_v_i,
  input  vaddr_t          br_npc_i,
  input  logic            br_branch_i,
  input  logic            br_taken_i,
  input  logic            isd_v_i,
  input  vaddr_t          isd_pc_i,
  input  bmeta_t          isd_meta_i,
  input  logic            commit_npc_w_v_i,
  input  vaddr_t          commit_npc_i,
  input  logic            commit_unfreeze_i,
  input  logic            commit_sfence_i,
  input  logic            commit_wfi_i,
  input  logic            commit_fencei_i,
  input  logic            commit_eret_i,
  input  logic            commit_trap_i,
  output vaddr_t          expected_npc_o,
  output logic            poison_isd_o,
  output logic            suppress_iss_o,
  output logic            unfreeze_o,
  output fe_opcode_e      fe_cmd_opcode_o,
  output vaddr_t          fe_cmd_npc_o,
  output redirect_subop_e fe_cmd_subop_o,
  output mispred_reason_e fe_cmd_reason_o,
  output logic            fe_cmd_taken_o,
  output bmeta_t          fe_cmd_meta_o,
  output logic            fe_cmd_v_o,
  input  logic            fe_cmd_yumi_i,
  output logic            cmd_empty_o,
  output logic            cmd_full_o
);

  logic            npc_mismatch;
  logic            last_branch;
  logic            last_taken;
  logic            in_wait;
  logic            enq_v;
  logic            enq_ready;
  logic            empty_next;
  fe_opcode_e      enq_opcode;
  vaddr_t          enq_npc;
  redirect_subop_e enq_subop;
  mispred_reason_e enq_reason;
  logic            enq_taken;
  bmeta_t          enq_meta;

  npc_tracker tracker0 (
    .clk_i(clk_i), .reset_i(reset_i),
    .br_v_i(br_v_i), .br_npc_i(br_npc_i),
    .br_branch_i(br_branch_i), .br_taken_i(br_taken_i),
    .commit_npc_w_v_i(commit_npc_w_v_i), .commit_npc_i(commit_npc_i),
    .isd_v_i(isd_v_i), .isd_pc_i(isd_pc_i),
    .expected_npc_o(expected_npc_o), .npc_mismatch_o(npc_mismatch),
    .poison_isd_o(poison_isd_o),
    .last_branch_o(last_branch), .last_taken_o(last_taken)
  );

  fe_cmd_encoder encoder0 (
    .commit_unfreeze_i(commit_unfreeze_i), .commit_sfence_i(commit_sfence_i),
    .commit_wfi_i(commit_wfi_i), .commit_fencei_i(commit_fencei_i),
    .commit_eret_i(commit_eret_i), .commit_trap_i(commit_trap_i),
    .commit_npc_i(commit_npc_i),
    .isd_v_i(isd_v_i), .isd_meta_i(isd_meta_i),
    .irq_waiting_i(irq_waiting_i), .in_wait_i(in_wait),
    .expected_npc_i(expected_npc_o), .npc_mismatch_i(npc_mismatch),
    .last_branch_i(last_branch), .last_taken_i(last_taken),
    .enq_ready_i(enq_ready), .enq_v_o(enq_v),
    .enq_opcode_o(enq_opcode), .enq_npc_o(enq_npc),
    .enq_subop_o(enq_subop), .enq_reason_o(enq_reason),
    .enq_taken_o(enq_taken), .enq_meta_o(enq_meta)
  );

  fe_cmd_queue queue0 (
    .clk_i(clk_i), .reset_i(reset_i),
    .enq_v_i(enq_v), .enq_opcode_i(enq_opcode), .enq_npc_i(enq_npc),
    .enq_subop_i(enq_subop), .enq_reason_i(enq_reason),
    .enq_taken_i(enq_taken), .enq_meta_i(enq_meta),
    .enq_ready_o(enq_ready),
    .fe_cmd_opcode_o(fe_cmd_opcode_o), .fe_cmd_npc_o(fe_cmd_npc_o),
    .fe_cmd_subop_o(fe_cmd_subop_o), .fe_cmd_reason_o(fe_cmd_reason_o),
    .fe_cmd_taken_o(fe_cmd_taken_o), .fe_cmd_meta_o(fe_cmd_meta_o),
    .fe_cmd_v_o(fe_cmd_v_o), .fe_cmd_yumi_i(fe_cmd_yumi_i),
    .empty_next_o(empty_next), .empty_o(cmd_empty_o), .full_o(cmd_full_o)
  );

  pc_director_ctrl ctrl0 (
    .clk_i(clk_i), .reset_i(reset_i),
    .freeze_i(freeze_i), .commit_wfi_i(commit_wfi_i),
    .enq_v_i(enq_v), .enq_opcode_i(enq_opcode),
    .empty_next_i(empty_next),
    .in_wait_o(in_wait), .suppress_iss_o(suppress_iss_o),
    .unfreeze_o(unfreeze_o)
  );

endmodule

// ==== tb_pc_director.sv ====
// ######################################################################
// PC director testbench
// Drives branch, issue and commit events, models the expected commands
// and checks the DUT outputs with concurrent assertions
// ######################################################################

`timescale 1ns/10ps

`include "pcdir_consts.svh"

module tb_pc_director
  import pcdir_pkg::*;
;

  localparam int max_cycles_lp = 2000;

  logic clk_i = 1'b0;
  logic reset_i, freeze_i, irq_waiting_i;
  logic br_v_i, br_branch_i, br_taken_i, isd_v_i, commit_npc_w_v_i;
  logic commit_unfreeze_i, commit_sfence_i, commit_wfi_i;
  logic commit_fencei_i, commit_eret_i, commit_trap_i, fe_cmd_yumi_i;
  vaddr_t br_npc_i, isd_pc_i, commit_npc_i;
  bmeta_t isd_meta_i;

  vaddr_t expected_npc_o, fe_cmd_npc_o;
  logic poison_isd_o, suppress_iss_o, unfreeze_o, fe_cmd_taken_o, fe_cmd_v_o;
  logic cmd_empty_o, cmd_full_o;
  fe_opcode_e fe_cmd_opcode_o;
  redirect_subop_e fe_cmd_subop_o;
  mispred_reason_e fe_cmd_reason_o;
  bmeta_t fe_cmd_meta_o;

  // Model state for this cycle (cur_) and after the next edge (nxt_)
  dir_state_e cur_state, nxt_state;
  vaddr_t cur_npc, nxt_npc, exp_npc;
  logic cur_br, nxt_br, cur_tk, nxt_tk, exp_poison;
  int cur_count, nxt_count;
  logic chk_en, auto_drain;
  string test_name;
  int cycles;

  logic [47:0] exp_mem [0:127];
  int exp_wr, exp_rd;
  logic [47:0] exp_head, act_cmd;
  logic accept;

  assign exp_head = exp_mem[exp_rd[6:0]];
  assign act_cmd  = {fe_cmd_opcode_o, fe_cmd_npc_o, fe_cmd_subop_o, fe_cmd_reason_o,
                     fe_cmd_taken_o, fe_cmd_meta_o};
  assign accept   = fe_cmd_v_o & fe_cmd_yumi_i;

  pc_director dut0 (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (accept)
      exp_rd <= exp_rd + 1;
    if (cycles >= max_cycles_lp)
      fail_run("run timed out before all tests completed");
  end

  task automatic fail_run(input string why);
    $display("%s (test %s)", why, test_name);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic fail_value(input string what, input logic [47:0] exp, input logic [47:0] act);
    $display("mismatch %s: test %s expected %h actual %h", what, test_name, exp, act);
    $display("** FAIL **");
    $fatal(1);
  endtask

  a_cmd_expected: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> exp_rd != exp_wr)
    else fail_run("front end accepted a command the model did not expect");
  a_cmd_value: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> act_cmd == exp_head)
    else fail_value("fe command", $sampled(exp_head), $sampled(act_cmd));
  a_head_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_cmd_v_o & ~fe_cmd_yumi_i |=> $stable(act_cmd))
    else fail_run("head command changed while held without yumi");
  a_npc: assert property (@(posedge clk_i) disable iff (reset_i)
    chk_en |-> expected_npc_o == exp_npc)
    else fail_value("expected npc", $sampled(exp_npc), $sampled(expected_npc_o));
  a_poison: assert property (@(posedge clk_i) disable iff (reset_i)
    chk_en |-> poison_isd_o == exp_poison)
    else fail_value("poison", $sampled(exp_poison), $sampled(poison_isd_o));
  a_suppress: assert property (@(posedge clk_i) disable iff (reset_i)
    chk_en |-> suppress_iss_o == (cur_state != e_run))
    else fail_value("suppress", $sampled(cur_state != e_run), $sampled(suppress_iss_o));
  a_unfreeze: assert property (@(posedge clk_i) disable iff (reset_i)
    chk_en |-> unfreeze_o == ((cur_state == e_freeze) & ~freeze_i))
    else fail_value("unfreeze", $sampled((cur_state == e_freeze) & ~freeze_i),
                    $sampled(unfreeze_o));
  a_queue_status: assert property (@(posedge clk_i) disable iff (reset_i)
    chk_en |-> {fe_cmd_v_o, cmd_empty_o, cmd_full_o} ==
      {cur_count != 0, cur_count == 0, cur_count == `PCDIR_CMDQ_DEPTH})
    else fail_value("queue status",
      $sampled({cur_count != 0, cur_count == 0, cur_count == `PCDIR_CMDQ_DEPTH}),
      $sampled({fe_cmd_v_o, cmd_empty_o, cmd_full_o}));

  task automatic cycle_start();
    @(posedge clk_i);
    #2;
    cur_state = nxt_state;
    cur_npc   = nxt_npc;
    cur_br    = nxt_br;
    cur_tk    = nxt_tk;
    cur_count = nxt_count;
    {br_v_i, br_branch_i, br_taken_i, isd_v_i, commit_npc_w_v_i, irq_waiting_i} = '0;
    {commit_unfreeze_i, commit_sfence_i, commit_wfi_i} = '0;
    {commit_fencei_i, commit_eret_i, commit_trap_i} = '0;
    fe_cmd_yumi_i = auto_drain & fe_cmd_v_o;
  endtask

  // Expected outputs and command for the inputs driven this cycle
  task automatic cycle_end();
    logic lb, lt, mism, has, enq;
    fe_opcode_e op;
    vaddr_t cn;
    redirect_subop_e so;
    mispred_reason_e rs;
    logic tk;
    bmeta_t mt;
    if (commit_npc_w_v_i)
      exp_npc = commit_npc_i;
    else if (br_v_i)
      exp_npc = br_npc_i;
    else
      exp_npc = cur_npc;
    mism = isd_v_i & (exp_npc != isd_pc_i);
    exp_poison = commit_npc_w_v_i | mism;
    lb = cur_br | (br_v_i & br_branch_i);
    lt = cur_tk | (br_v_i & br_taken_i);
    has = 1'b1;
    op = e_op_pc_redirection;
    cn = commit_npc_i;
    so = e_subop_none;
    rs = e_not_a_branch;
    tk = 1'b0;
    mt = '0;
    if (commit_unfreeze_i)
    begin
      op = e_op_state_reset;
      cn = exp_npc;
    end
    else if (commit_sfence_i)
      op = e_op_itlb_fence;
    else if (commit_wfi_i)
      op = e_op_wait;
    else if (commit_fencei_i)
      op = e_op_icache_fence;
    else if (commit_eret_i)
      so = e_subop_eret;
    else if (commit_trap_i | ((cur_state == e_wait) & irq_waiting_i))
      so = e_subop_trap;
    else if (mism)
    begin
      cn = exp_npc;
      so = e_subop_branch_mispredict;
      mt = isd_meta_i;
      rs = !lb ? e_not_a_branch : (lt ? e_incorrect_pred_taken : e_incorrect_pred_ntaken);
    end
    else if (isd_v_i & lb)
    begin
      op = e_op_attaboy;
      cn = exp_npc;
      tk = lt;
      mt = isd_meta_i;
    end
    else
      has = 1'b0;
    // Full queue drops the event
    enq = has & (cur_count < `PCDIR_CMDQ_DEPTH);
    if (enq)
    begin
      exp_mem[exp_wr[6:0]] = {op, cn, so, rs, tk, mt};
      exp_wr++;
    end
    nxt_npc   = exp_npc;
    nxt_br    = ~isd_v_i & lb;
    nxt_tk    = ~isd_v_i & lt;
    nxt_count = cur_count + int'(enq) - int'(fe_cmd_yumi_i);
    nxt_state = cur_state;
    case (cur_state)
      e_freeze: if (!freeze_i) nxt_state = e_wait;
      e_wait:   if (enq && op != e_op_attaboy) nxt_state = e_fence;
      e_run:
        if (commit_wfi_i)
          nxt_state = e_wait;
        else if (enq && op != e_op_attaboy)
          nxt_state = e_fence;
      default:  if (nxt_count == 0) nxt_state = e_run;
    endcase
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      cycle_start();
      cycle_end();
    end
  endtask

  // Interrupt that pulls the director out of wait
  task automatic wake_with_irq();
    cycle_start();
    irq_waiting_i = 1'b1;
    commit_npc_i = $urandom;
    cycle_end();
  endtask

  // Drain with yumi until the director is back in run
  task automatic wait_run_drained();
    auto_drain = 1'b1;
    do
      idle(1);
    while (suppress_iss_o || !cmd_empty_o);
  endtask

  initial
  begin
    int flags;
    void'($urandom(32'hb9e749b8));
    {reset_i, freeze_i} = 2'b11;
    {br_v_i, br_branch_i, br_taken_i, isd_v_i, commit_npc_w_v_i, irq_waiting_i} = '0;
    {commit_unfreeze_i, commit_sfence_i, commit_wfi_i} = '0;
    {commit_fencei_i, commit_eret_i, commit_trap_i, fe_cmd_yumi_i} = '0;
    {br_npc_i, isd_pc_i, commit_npc_i, isd_meta_i} = '0;
    cur_state = e_freeze;
    nxt_state = e_freeze;
    {cur_npc, nxt_npc, exp_npc} = '0;
    {cur_br, nxt_br, cur_tk, nxt_tk, exp_poison, chk_en, auto_drain} = '0;
    {cur_count, nxt_count, exp_wr, exp_rd, cycles} = '0;
    test_name = "reset_boot";
    repeat (16) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    chk_en = 1'b1;
    idle(3);
    cycle_start();
    freeze_i = 1'b0;
    cycle_end();
    idle(3);
    cycle_start();
    commit_unfreeze_i = 1'b1;
    cycle_end();
    wait_run_drained();

    test_name = "npc_tracking";
    repeat (12)
    begin
      cycle_start();
      {br_v_i, commit_npc_w_v_i} = $urandom_range(0, 3);
      br_npc_i = $urandom;
      commit_npc_i = $urandom;
      isd_v_i = $urandom_range(0, 1);
      isd_pc_i = $urandom_range(0, 1) ? br_npc_i : $urandom;
      cycle_end();
      idle(1);
    end
    wait_run_drained();

    test_name = "mispredict_attaboy";
    repeat (10)
    begin
      cycle_start();
      {br_v_i, br_branch_i} = 2'b11;
      br_taken_i = $urandom_range(0, 1);
      br_npc_i = $urandom;
      cycle_end();
      cycle_start();
      isd_v_i = 1'b1;
      isd_meta_i = $urandom;
      isd_pc_i = $urandom_range(0, 1) ? cur_npc : $urandom;
      cycle_end();
      wait_run_drained();
    end

    test_name = "commit_priority";
    repeat (12)
    begin
      cycle_start();
      flags = $urandom_range(1, 63);
      {commit_unfreeze_i, commit_sfence_i, commit_wfi_i} = flags[5:3];
      {commit_fencei_i, commit_eret_i, commit_trap_i} = flags[2:0];
      commit_npc_i = $urandom;
      cycle_end();
      if (nxt_state == e_wait)
        wake_with_irq();
      wait_run_drained();
    end
    cycle_start();
    commit_wfi_i = 1'b1;
    commit_npc_i = $urandom;
    cycle_end();
    idle(2);
    wake_with_irq();
    wait_run_drained();

    test_name = "queue_backpressure";
    auto_drain = 1'b0;
    repeat (`PCDIR_CMDQ_DEPTH + 1)
    begin
      cycle_start();
      commit_sfence_i = 1'b1;
      commit_npc_i = $urandom;
      cycle_end();
    end
    idle(4);
    wait_run_drained();

    idle(2);
    if (exp_rd != exp_wr)
      fail_run("expected commands never reached the front end");
    else
    begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+.
pcdir_pkg.sv
npc_tracker.sv
fe_cmd_encoder.sv
fe_cmd_queue.sv
pc_director_ctrl.sv
pc_director.sv
tb_pc_director.sv

// ==== Bender.yml ====
package:
  name: pc_director

export_include_dirs:
  - .

sources:
  - pcdir_pkg.sv
  - npc_tracker.sv
  - fe_cmd_encoder.sv
  - fe_cmd_queue.sv
  - pc_director_ctrl.sv
  - pc_director.sv
  - target: test
    files:
      - tb_pc_director.sv
